// File: logic/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

	// bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int SEL_W  = DATA_W / 8;

	// scratch ram size
	localparam int RAM_WORDS = 256;
	localparam int RAM_AW    = $clog2(RAM_WORDS);

	// memory map
	localparam logic [ADDR_W-1:0] RAM_BASE  = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] RAM_BYTES = RAM_WORDS * SEL_W;
	localparam logic [ADDR_W-1:0] GPIO_BASE = 32'h0000_1000;

	// gpio register offsets inside the gpio window
	localparam logic [ADDR_W-1:0] GPIO_OUT_OFS = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] GPIO_IN_OFS  = 32'h0000_0004;

	// gpio width, read back zero-extended
	localparam int GPIO_W = 16;

	// target of the current access
	typedef enum logic [1:0] {
		SEL_NONE = 2'd0,
		SEL_RAM  = 2'd1,
		SEL_GPIO = 2'd2
	} slave_sel_e;

	// decoder sequencing
	typedef enum logic [1:0] {
		BUS_IDLE   = 2'd0,
		BUS_ACCESS = 2'd1,
		BUS_RESP   = 2'd2
	} bus_state_e;

endpackage

`default_nettype wire

// File: logic/wb_addr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module wb_addr_decode import soc_bus_pkg::*; (
	input  wire                clk,
	input  wire                rst_i,
	input  wire [ADDR_W-1:0]   adr_i,
	input  wire [DATA_W-1:0]   dat_i,
	input  wire [SEL_W-1:0]    sel_i,
	input  wire                we_i,
	input  wire                cyc_i,
	input  wire                stb_i,
	output logic [ADDR_W-1:0]  req_adr_o,
	output logic [DATA_W-1:0]  req_dat_o,
	output logic [SEL_W-1:0]   req_sel_o,
	output logic               req_we_o,
	output logic               ram_stb_o,
	output logic               gpio_stb_o,
	output slave_sel_e         slave_sel_o,
	output logic               resp_phase_o
);

	bus_state_e state_q;
	slave_sel_e decode_sel;
	logic [ADDR_W-1:0] word_adr;
	logic accept;

	// only take a new request when nothing is in flight
	assign accept = (state_q == BUS_IDLE) && cyc_i && stb_i;
	assign word_adr = {adr_i[ADDR_W-1:2], 2'b00};

	// address map, the subtraction wraps for addresses below the base
	always_comb begin
		if ((adr_i - RAM_BASE) < RAM_BYTES) begin
			decode_sel = SEL_RAM;
		end else if ((word_adr == (GPIO_BASE + GPIO_OUT_OFS)) ||
			(word_adr == (GPIO_BASE + GPIO_IN_OFS))) begin
			decode_sel = SEL_GPIO;
		end else begin
			decode_sel = SEL_NONE;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q     <= BUS_IDLE;
			slave_sel_o <= SEL_NONE;
		end else begin
			case (state_q)
				BUS_IDLE: begin
					if (accept) begin
						state_q     <= BUS_ACCESS;
						slave_sel_o <= decode_sel;
					end
				end
				BUS_ACCESS: state_q <= BUS_RESP;
				BUS_RESP:   state_q <= BUS_IDLE;
				default:    state_q <= BUS_IDLE;
			endcase
		end
	end

	// request bundle held for the slaves
	always_ff @(posedge clk) begin
		if (accept) begin
			req_adr_o <= adr_i;
			req_dat_o <= dat_i;
			req_sel_o <= sel_i;
			req_we_o  <= we_i;
		end
	end

	assign ram_stb_o    = (state_q == BUS_ACCESS) && (slave_sel_o == SEL_RAM);
	assign gpio_stb_o   = (state_q == BUS_ACCESS) && (slave_sel_o == SEL_GPIO);
	assign resp_phase_o = (state_q == BUS_RESP);

endmodule

`default_nettype wire

// File: logic/wb_ram_slave.sv
`timescale 1ns/1ns
`default_nettype none

module wb_ram_slave import soc_bus_pkg::*; (
	input  wire                clk,
	input  wire                rst_i,
	input  wire                stb_i,
	input  wire                we_i,
	input  wire [ADDR_W-1:0]   adr_i,
	input  wire [DATA_W-1:0]   dat_i,
	input  wire [SEL_W-1:0]    sel_i,
	output logic [DATA_W-1:0]  dat_o,
	output logic               ack_o
);

	logic [DATA_W-1:0] mem [RAM_WORDS];
	logic [RAM_AW-1:0] word_idx;

	// word index sits above the byte offset
	assign word_idx = adr_i[RAM_AW+1:2];

	// byte lane writes
	always_ff @(posedge clk) begin
		if (stb_i && we_i) begin
			for (int lane = 0; lane < SEL_W; lane++) begin
				if (sel_i[lane]) begin
					mem[word_idx][lane*8 +: 8] <= dat_i[lane*8 +: 8];
				end
			end
		end
	end

	// registered read port
	always_ff @(posedge clk) begin
		if (stb_i && !we_i) begin
			dat_o <= mem[word_idx];
		end
	end

	// single cycle ack after the strobe
	always_ff @(posedge clk) begin
		if (rst_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= stb_i;
		end
	end

endmodule

`default_nettype wire

// File: logic/wb_gpio_slave.sv
`timescale 1ns/1ns
`default_nettype none

module wb_gpio_slave import soc_bus_pkg::*; (
	input  wire                clk,
	input  wire                rst_i,
	input  wire                stb_i,
	input  wire                we_i,
	input  wire [ADDR_W-1:0]   adr_i,
	input  wire [DATA_W-1:0]   dat_i,
	input  wire [SEL_W-1:0]    sel_i,
	input  wire [GPIO_W-1:0]   gpio_i,
	output logic [DATA_W-1:0]  dat_o,
	output logic               ack_o,
	output logic [GPIO_W-1:0]  gpio_o
);

	logic [GPIO_W-1:0] in_meta_q;
	logic [GPIO_W-1:0] in_q;
	logic is_out_reg;
	logic is_in_reg;

	// register select from the word offset
	assign is_out_reg = (adr_i[3:2] == GPIO_OUT_OFS[3:2]);
	assign is_in_reg  = (adr_i[3:2] == GPIO_IN_OFS[3:2]);

	// two flop synchronizer for the async pins
	always_ff @(posedge clk) begin
		in_meta_q <= gpio_i;
		in_q      <= in_meta_q;
	end

	// output register, only the low two byte lanes exist
	always_ff @(posedge clk) begin
		if (rst_i) begin
			gpio_o <= '0;
		end else if (stb_i && we_i && is_out_reg) begin
			for (int lane = 0; lane < GPIO_W / 8; lane++) begin
				if (sel_i[lane]) begin
					gpio_o[lane*8 +: 8] <= dat_i[lane*8 +: 8];
				end
			end
		end
	end

	// read data, zero-extended to the bus width
	always_ff @(posedge clk) begin
		if (stb_i && !we_i) begin
			if (is_in_reg) begin
				dat_o <= {{(DATA_W-GPIO_W){1'b0}}, in_q};
			end else begin
				dat_o <= {{(DATA_W-GPIO_W){1'b0}}, gpio_o};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= stb_i;
		end
	end

endmodule

`default_nettype wire

// File: logic/wb_resp_mux.sv
`timescale 1ns/1ns
`default_nettype none

module wb_resp_mux import soc_bus_pkg::*; (
	input  slave_sel_e         slave_sel_i,
	input  wire                resp_phase_i,
	input  wire [DATA_W-1:0]   ram_dat_i,
	input  wire                ram_ack_i,
	input  wire [DATA_W-1:0]   gpio_dat_i,
	input  wire                gpio_ack_i,
	output logic [DATA_W-1:0]  dat_o,
	output logic               ack_o,
	output logic               err_o
);

	// route the selected slave back to the master
	always_comb begin
		case (slave_sel_i)
			SEL_RAM: begin
				dat_o = ram_dat_i;
				ack_o = ram_ack_i;
			end
			SEL_GPIO: begin
				dat_o = gpio_dat_i;
				ack_o = gpio_ack_i;
			end
			default: begin
				dat_o = '0;
				ack_o = 1'b0;
			end
		endcase
	end

	// unmapped access answered in the decoder's response cycle
	assign err_o = resp_phase_i && (slave_sel_i == SEL_NONE);

endmodule

`default_nettype wire

// File: logic/soc_bus_top.sv
`timescale 1ns/1ns
`default_nettype none

module soc_bus_top import soc_bus_pkg::*; (
	input  wire                clk,
	input  wire                rst_i,
	input  wire [ADDR_W-1:0]   adr_i,
	input  wire [DATA_W-1:0]   dat_i,
	input  wire [SEL_W-1:0]    sel_i,
	input  wire                we_i,
	input  wire                cyc_i,
	input  wire                stb_i,
	input  wire [GPIO_W-1:0]   gpio_i,
	output wire [DATA_W-1:0]   dat_o,
	output wire                ack_o,
	output wire                err_o,
	output wire [GPIO_W-1:0]   gpio_o
);

	// request bundle shared by both slaves
	wire [ADDR_W-1:0] req_adr;
	wire [DATA_W-1:0] req_dat;
	wire [SEL_W-1:0]  req_sel;
	wire              req_we;

	wire              ram_stb;
	wire              gpio_stb;
	slave_sel_e       slave_sel;
	wire              resp_phase;

	// slave responses
	wire [DATA_W-1:0] ram_dat;
	wire              ram_ack;
	wire [DATA_W-1:0] gpio_dat;
	wire              gpio_ack;

	wb_addr_decode decode_i (
		.clk          (clk),
		.rst_i        (rst_i),
		.adr_i        (adr_i),
		.dat_i        (dat_i),
		.sel_i        (sel_i),
		.we_i         (we_i),
		.cyc_i        (cyc_i),
		.stb_i        (stb_i),
		.req_adr_o    (req_adr),
		.req_dat_o    (req_dat),
		.req_sel_o    (req_sel),
		.req_we_o     (req_we),
		.ram_stb_o    (ram_stb),
		.gpio_stb_o   (gpio_stb),
		.slave_sel_o  (slave_sel),
		.resp_phase_o (resp_phase)
	);

	wb_ram_slave ram_i (
		.clk   (clk),
		.rst_i (rst_i),
		.stb_i (ram_stb),
		.we_i  (req_we),
		.adr_i (req_adr),
		.dat_i (req_dat),
		.sel_i (req_sel),
		.dat_o (ram_dat),
		.ack_o (ram_ack)
	);

	wb_gpio_slave gpio_i_slave (
		.clk    (clk),
		.rst_i  (rst_i),
		.stb_i  (gpio_stb),
		.we_i   (req_we),
		.adr_i  (req_adr),
		.dat_i  (req_dat),
		.sel_i  (req_sel),
		.gpio_i (gpio_i),
		.dat_o  (gpio_dat),
		.ack_o  (gpio_ack),
		.gpio_o (gpio_o)
	);

	wb_resp_mux resp_i (
		.slave_sel_i  (slave_sel),
		.resp_phase_i (resp_phase),
		.ram_dat_i    (ram_dat),
		.ram_ack_i    (ram_ack),
		.gpio_dat_i   (gpio_dat),
		.gpio_ack_i   (gpio_ack),
		.dat_o        (dat_o),
		.ack_o        (ack_o),
		.err_o        (err_o)
	);

endmodule

`default_nettype wire

// File: test/soc_bus_assert.sv
`timescale 1ns/1ns
`default_nettype none

module soc_bus_assert import soc_bus_pkg::*; (
	input wire clk,
	input wire rst_i,
	input wire cyc_i,
	input wire stb_i,
	input wire ack_o,
	input wire err_o
);

	logic violation = 1'b0;
	wire resp = ack_o || err_o;

	// a cycle ends in ack or err, never both
	ack_err_exclusive: assert property (@(posedge clk) disable iff (rst_i) !(ack_o && err_o))
		else begin
			violation = 1'b1;
			$error("ack_o and err_o high together");
		end

	one_cycle_resp: assert property (@(posedge clk) disable iff (rst_i) resp |=> !resp)
		else begin
			violation = 1'b1;
			$error("response held for more than one cycle");
		end

	// response follows a request taken two edges earlier
	resp_has_request: assert property (@(posedge clk) disable iff (rst_i)
		resp |-> $past(cyc_i && stb_i, 2))
		else begin
			violation = 1'b1;
			$error("response without a matching request");
		end

endmodule

bind soc_bus_top soc_bus_assert assert_i (
	.clk   (clk),
	.rst_i (rst_i),
	.cyc_i (cyc_i),
	.stb_i (stb_i),
	.ack_o (ack_o),
	.err_o (err_o)
);

`default_nettype wire

// File: test/soc_bus_tb.sv
`timescale 1ns/1ns
`default_nettype none

module soc_bus_tb import soc_bus_pkg::*; ();

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 3;
	// response seen on the second falling edge after the request is driven
	localparam int RESP_LATENCY = 2;
	localparam int MAX_WAIT     = 8;
	localparam int N_TRANSFERS  = 41;
	localparam int RAM_SWEEP    = 16;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	localparam logic [ADDR_W-1:0] UNMAPPED_ADR = 32'h0000_2000;

	logic clk;
	logic rst_i;
	logic [ADDR_W-1:0] adr_i;
	logic [DATA_W-1:0] dat_i;
	logic [SEL_W-1:0] sel_i;
	logic we_i;
	logic cyc_i;
	logic stb_i;
	logic [GPIO_W-1:0] gpio_i;
	wire [DATA_W-1:0] dat_o;
	wire ack_o;
	wire err_o;
	wire [GPIO_W-1:0] gpio_o;

	logic [31:0] lfsr_q;
	// reference copy of the scratch ram
	logic [DATA_W-1:0] model [RAM_WORDS];
	bit written [RAM_WORDS];
	int word_q[$];

	soc_bus_top dut_i (
		.clk    (clk),
		.rst_i  (rst_i),
		.adr_i  (adr_i),
		.dat_i  (dat_i),
		.sel_i  (sel_i),
		.we_i   (we_i),
		.cyc_i  (cyc_i),
		.stb_i  (stb_i),
		.gpio_i (gpio_i),
		.dat_o  (dat_o),
		.ack_o  (ack_o),
		.err_o  (err_o),
		.gpio_o (gpio_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// galois lfsr stepped once per bit handed out
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] value;
		logic out_bit;
		value = '0;
		for (int i = 0; i < n; i++) begin
			out_bit = lfsr_q[0];
			lfsr_q = lfsr_q >> 1;
			if (out_bit) begin
				lfsr_q = lfsr_q ^ LFSR_TAPS;
			end
			value = {value[30:0], out_bit};
		end
		return value;
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		abort_run($sformatf("FAILED at %0t ns: %s", $time, msg));
	endtask

	// one classic cycle where the master holds the request until ack or err
	task automatic run_transfer(
		input logic [ADDR_W-1:0] adr,
		input logic [DATA_W-1:0] wdata,
		input logic [SEL_W-1:0] sel,
		input logic we,
		input logic expect_err,
		output logic [DATA_W-1:0] rdata
	);
		int cycles;
		logic got_ack;
		logic got_err;
		@(negedge clk);
		adr_i = adr;
		dat_i = wdata;
		sel_i = sel;
		we_i = we;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		cycles = 0;
		got_ack = 1'b0;
		got_err = 1'b0;
		while (!got_ack && !got_err && cycles < MAX_WAIT) begin
			@(negedge clk);
			cycles++;
			got_ack = ack_o;
			got_err = err_o;
		end
		rdata = dat_o;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		assert (got_ack || got_err)
			else abort_run($sformatf("no response to the access at 0x%08h", adr));
		assert (got_err == expect_err && got_ack == !expect_err)
			else report_mismatch($sformatf("0x%08h answered ack=%0b err=%0b, expected err=%0b",
				adr, got_ack, got_err, expect_err));
		assert (cycles == RESP_LATENCY)
			else report_mismatch($sformatf("0x%08h answered after %0d cycles", adr, cycles));
		@(negedge clk);
		assert (!ack_o && !err_o)
			else report_mismatch($sformatf("response to 0x%08h lasted more than a cycle", adr));
	endtask

	task automatic bus_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] wdata,
		input logic [SEL_W-1:0] sel);
		logic [DATA_W-1:0] ignored;
		run_transfer(adr, wdata, sel, 1'b1, 1'b0, ignored);
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] rdata);
		run_transfer(adr, '0, '1, 1'b0, 1'b0, rdata);
	endtask

	task automatic check_reset_state();
		@(negedge clk);
		assert (!ack_o && !err_o) else report_mismatch("ack_o or err_o high after reset");
		assert (gpio_o == '0)
			else report_mismatch($sformatf("gpio_o is 0x%04h after reset", gpio_o));
	endtask

	task automatic ram_word_sweep();
		int idx;
		logic [DATA_W-1:0] rdata;
		for (int n = 0; n < RAM_SWEEP; n++) begin
			idx = take_bits(RAM_AW);
			// skip words already in use so every address is distinct
			while (written[idx]) begin
				idx = (idx + 1) % RAM_WORDS;
			end
			written[idx] = 1'b1;
			model[idx] = take_bits(DATA_W);
			word_q.push_back(idx);
			bus_write(RAM_BASE + idx * 4, model[idx], 4'hf);
		end
		foreach (word_q[i]) begin
			bus_read(RAM_BASE + word_q[i] * 4, rdata);
			assert (rdata == model[word_q[i]])
				else report_mismatch($sformatf("ram word %0d read 0x%08h, expected 0x%08h",
					word_q[i], rdata, model[word_q[i]]));
		end
	endtask

	task automatic byte_lane_merge();
		int idx;
		logic [SEL_W-1:0] sel;
		logic [DATA_W-1:0] wdata;
		logic [DATA_W-1:0] expected;
		logic [DATA_W-1:0] rdata;
		idx = word_q[0];
		sel = SEL_W'(take_bits(SEL_W));
		if (sel == '0 || sel == '1) begin
			sel = 4'b0110;
		end
		wdata = take_bits(DATA_W);
		expected = model[idx];
		for (int lane = 0; lane < SEL_W; lane++) begin
			if (sel[lane]) begin
				expected[lane*8 +: 8] = wdata[lane*8 +: 8];
			end
		end
		bus_write(RAM_BASE + idx * 4, wdata, sel);
		model[idx] = expected;
		bus_read(RAM_BASE + idx * 4, rdata);
		assert (rdata == expected)
			else report_mismatch($sformatf("sel %b merge read 0x%08h, expected 0x%08h",
				sel, rdata, expected));
	endtask

	task automatic gpio_loopback();
		logic [DATA_W-1:0] wdata;
		logic [GPIO_W-1:0] pins;
		logic [DATA_W-1:0] rdata;
		wdata = take_bits(DATA_W);
		bus_write(GPIO_BASE + GPIO_OUT_OFS, wdata, 4'hf);
		assert (gpio_o == wdata[GPIO_W-1:0])
			else report_mismatch($sformatf("gpio_o is 0x%04h after writing 0x%08h",
				gpio_o, wdata));
		bus_read(GPIO_BASE + GPIO_OUT_OFS, rdata);
		assert (rdata == {{(DATA_W-GPIO_W){1'b0}}, wdata[GPIO_W-1:0]})
			else report_mismatch($sformatf("gpio out register read 0x%08h", rdata));
		pins = GPIO_W'(take_bits(GPIO_W));
		@(negedge clk);
		gpio_i = pins;
		// let the pins settle through the synchronizer
		repeat (4) @(negedge clk);
		bus_read(GPIO_BASE + GPIO_IN_OFS, rdata);
		assert (rdata == {{(DATA_W-GPIO_W){1'b0}}, pins})
			else report_mismatch($sformatf("gpio in register read 0x%08h, pins 0x%04h",
				rdata, pins));
	endtask

	task automatic unmapped_access();
		logic [DATA_W-1:0] wdata;
		logic [DATA_W-1:0] rdata;
		int idx;
		// ram word the unmapped address would land on if it leaked through
		idx = (UNMAPPED_ADR / 4) % RAM_WORDS;
		model[idx] = take_bits(DATA_W);
		bus_write(RAM_BASE + idx * 4, model[idx], 4'hf);
		wdata = ~model[idx];
		run_transfer(UNMAPPED_ADR, wdata, 4'hf, 1'b1, 1'b1, rdata);
		run_transfer(UNMAPPED_ADR, '0, 4'hf, 1'b0, 1'b1, rdata);
		assert (rdata == '0)
			else report_mismatch($sformatf("unmapped read returned 0x%08h", rdata));
		bus_read(RAM_BASE + idx * 4, rdata);
		assert (rdata == model[idx])
			else report_mismatch($sformatf("ram word %0d changed to 0x%08h", idx, rdata));
	endtask

	// watchdog sized from the transfer count
	initial begin
		#(N_TRANSFERS * 4 * CLK_PERIOD + 200);
		abort_run("timeout: the tests did not finish in the expected time");
	end

	initial begin
		wait (dut_i.assert_i.violation === 1'b1);
		abort_run("a bus handshake assertion fired");
	end

	initial begin
		lfsr_q = 32'd94475;
		rst_i = 1'b1;
		adr_i = '0;
		dat_i = '0;
		sel_i = '0;
		we_i = 1'b0;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		gpio_i = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;
		check_reset_state();
		ram_word_sweep();
		byte_lane_merge();
		gpio_loopback();
		unmapped_access();
		if (dut_i.assert_i.violation) begin
			abort_run("a bus handshake assertion fired during the run");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: compile.f
logic/soc_bus_pkg.sv
logic/wb_addr_decode.sv
logic/wb_ram_slave.sv
logic/wb_gpio_slave.sv
logic/wb_resp_mux.sv
logic/soc_bus_top.sv
test/soc_bus_assert.sv
test/soc_bus_tb.sv
